// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int addr_w = 20;          // byte address
	localparam int word_w = 16;
	localparam int line_words = 8;
	localparam int line_bytes = 16;
	localparam int stack_words = 4;      // most words one stack write carries

	typedef logic [word_w-1:0] word_t;

	// word 0 sits in the low bits of the line
	typedef word_t [line_words-1:0] line_t;

	// even bit is the low byte of a word, odd bit the high byte
	typedef logic [line_bytes-1:0] byte_mask_t;

	typedef enum logic [1:0] {
		acc_read,
		acc_word_write,
		acc_byte_write,
		acc_stack_write
	} access_kind_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		access_kind_t kind;
		logic [2:0] count;               // stack words, 1 to 4
		word_t [stack_words-1:0] wdata;  // used from wdata[0] upward
	} mem_req_t;

	// fill and write-back traffic
	typedef struct packed {
		logic [addr_w-5:0] line_addr;
		line_t data;
	} line_xfer_t;

endpackage

`default_nettype wire

// File: source/cache_tags.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tags #(
	parameter int ways = 4,
	parameter int sets = 64,
	localparam int set_w = $clog2(sets),
	localparam int way_w = $clog2(ways),
	localparam int tag_w = cache_pkg::addr_w - $clog2(cache_pkg::line_bytes) - set_w
) (
	input  logic main_clk,
	input  logic rst_n,
	input  logic [set_w-1:0] set_index,
	input  logic [tag_w-1:0] tag,
	input  logic [way_w-1:0] victim_way,
	input  logic tag_write,
	input  logic data_write,
	input  logic [way_w-1:0] access_way,
	output logic hit,
	output logic [way_w-1:0] hit_way,
	output logic [tag_w-1:0] victim_tag,
	output logic victim_dirty
);

	logic [tag_w-1:0] tag_mem [ways][sets];
	logic [ways-1:0] valid_q [sets];
	logic [ways-1:0] dirty_q [sets];

	// all ways compared at once, at most one can match
	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < ways; w++) begin
			if (valid_q[set_index][w] && tag_mem[w][set_index] == tag) begin
				hit = 1'b1;
				hit_way = way_w'(w);
			end
		end
	end

	assign victim_tag = tag_mem[victim_way][set_index];
	assign victim_dirty = valid_q[set_index][victim_way] & dirty_q[set_index][victim_way];

	always_ff @(posedge main_clk) begin
		if (tag_write) begin
			tag_mem[access_way][set_index] <= tag;
		end
	end

	always_ff @(posedge main_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < sets; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (tag_write) begin
			valid_q[set_index][access_way] <= 1'b1;  // fresh line is clean
			dirty_q[set_index][access_way] <= 1'b0;
		end else if (data_write) begin
			dirty_q[set_index][access_way] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lru #(
	parameter int ways = 4,
	parameter int sets = 64,
	localparam int set_w = $clog2(sets),
	localparam int way_w = $clog2(ways)
) (
	input  logic main_clk,
	input  logic rst_n,
	input  logic [set_w-1:0] set_index,
	input  logic [way_w-1:0] access_way,
	input  logic lru_touch,
	output logic [way_w-1:0] victim_way
);

	// age 0 is the oldest way, ways-1 the newest
	logic [way_w-1:0] age_q [sets][ways];

	always_comb begin
		victim_way = '0;
		for (int w = 0; w < ways; w++) begin
			if (age_q[set_index][w] == '0) begin
				victim_way = way_w'(w);
			end
		end
	end

	always_ff @(posedge main_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < sets; s++) begin
				for (int w = 0; w < ways; w++) begin
					age_q[s][w] <= way_w'(w);  // way 0 oldest after reset
				end
			end
		end else if (lru_touch) begin
			for (int w = 0; w < ways; w++) begin
				if (way_w'(w) == access_way) begin
					age_q[set_index][w] <= way_w'(ways - 1);
				end else if (age_q[set_index][w] > age_q[set_index][access_way]) begin
					age_q[set_index][w] <= age_q[set_index][w] - 1'b1;  // step toward oldest
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/cache_data.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data #(
	parameter int ways = 4,
	parameter int sets = 64,
	localparam int set_w = $clog2(sets),
	localparam int way_w = $clog2(ways)
) (
	input  logic main_clk,
	input  logic [set_w-1:0] set_index,
	input  logic [way_w-1:0] access_way,
	input  logic line_fill,
	input  cache_pkg::line_t fill_line,
	input  logic data_write,
	input  cache_pkg::byte_mask_t byte_mask,
	input  cache_pkg::line_t write_line,
	output cache_pkg::line_t rd_line
);

	import cache_pkg::*;

	line_t lines [ways][sets];

	always_ff @(posedge main_clk) begin
		if (line_fill) begin
			lines[access_way][set_index] <= fill_line;
		end else if (data_write) begin
			for (int b = 0; b < line_bytes; b++) begin
				if (byte_mask[b]) begin
					// byte b lives in word b/2, low half when b is even
					lines[access_way][set_index][b / 2][8 * (b % 2) +: 8] <=
						write_line[b / 2][8 * (b % 2) +: 8];
				end
			end
		end
	end

	// same read serves the requester and the write-back path
	assign rd_line = lines[access_way][set_index];

endmodule

`default_nettype wire

// File: source/write_merge.sv
`timescale 1ns/1ps
`default_nettype none

module write_merge (
	input  cache_pkg::mem_req_t cur_req,
	output cache_pkg::byte_mask_t byte_mask,
	output cache_pkg::line_t write_line
);

	import cache_pkg::*;

	logic [2:0] word_off;
	logic odd_byte;

	assign word_off = cur_req.addr[3:1];
	assign odd_byte = cur_req.addr[0];

	always_comb begin
		byte_mask = '0;
		write_line = '0;
		case (cur_req.kind)
			acc_word_write: begin
				write_line[word_off] = cur_req.wdata[0];
				byte_mask[2 * word_off +: 2] = 2'b11;
			end
			acc_byte_write: begin
				// byte copied into both halves, mask picks the one that lands
				for (int i = 0; i < line_words; i++) begin
					write_line[i] = {2{cur_req.wdata[0][7:0]}};
				end
				if (odd_byte) begin
					byte_mask[2 * word_off] = 1'b1;      // odd address, low byte
				end else begin
					byte_mask[2 * word_off + 1] = 1'b1;
				end
			end
			acc_stack_write: begin
				for (int i = 0; i < stack_words; i++) begin
					// words that run past the end of the line are dropped
					if (i < int'(cur_req.count) && int'(word_off) + i < line_words) begin
						write_line[int'(word_off) + i] = cur_req.wdata[i];
						byte_mask[2 * (int'(word_off) + i) +: 2] = 2'b11;
					end
				end
			end
			default: begin
				byte_mask = '0;  // read leaves the line alone
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
	parameter int ways = 4,
	parameter int sets = 64,
	localparam int off_w = $clog2(cache_pkg::line_bytes),
	localparam int set_w = $clog2(sets),
	localparam int way_w = $clog2(ways),
	localparam int tag_w = cache_pkg::addr_w - off_w - set_w
) (
	input  logic main_clk,
	input  logic rst_n,
	input  logic req_valid,
	input  cache_pkg::mem_req_t req,
	input  logic hit,
	input  logic [way_w-1:0] hit_way,
	input  logic [way_w-1:0] victim_way,
	input  logic [tag_w-1:0] victim_tag,
	input  logic victim_dirty,
	input  logic fill_valid,
	input  cache_pkg::line_xfer_t fill,
	output logic [set_w-1:0] set_index,
	output logic [tag_w-1:0] tag,
	output cache_pkg::mem_req_t cur_req,
	output logic [way_w-1:0] access_way,
	output logic tag_write,
	output logic line_fill,
	output logic data_write,
	output logic lru_touch,
	output logic fill_req_valid,
	output logic [cache_pkg::addr_w-off_w-1:0] fill_req_line,
	output logic wb_valid,
	output logic ack
);

	import cache_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_write_back,
		st_fill_wait,
		st_fill,
		st_apply
	} state_t;

	state_t state_q, state_d;
	mem_req_t req_q;
	logic [way_w-1:0] way_q;
	logic ack_q, fill_req_q;
	logic is_write, needs_wb, fill_match;

	assign set_index = req_q.addr[off_w +: set_w];
	assign tag = req_q.addr[addr_w-1 -: tag_w];
	assign cur_req = req_q;
	assign fill_req_line = req_q.addr[addr_w-1:off_w];
	assign is_write = req_q.kind != acc_read;
	// a valid victim on a miss always holds some other line
	assign needs_wb = victim_dirty && victim_tag != tag;
	assign fill_match = fill_valid && fill.line_addr == fill_req_line;

	// way is chosen during lookup, then held for the rest of the access
	assign access_way = (state_q == st_lookup) ? (hit ? hit_way : victim_way) : way_q;

	assign wb_valid = state_q == st_write_back;  // rd_line already shows the victim
	assign fill_req_valid = fill_req_q;
	assign ack = ack_q;

	always_comb begin
		state_d = state_q;
		tag_write = 1'b0;
		line_fill = 1'b0;
		data_write = 1'b0;
		lru_touch = 1'b0;
		case (state_q)
			st_idle: begin
				if (req_valid) begin
					state_d = st_lookup;
				end
			end
			st_lookup: begin
				if (hit) begin
					data_write = is_write;  // dirty marking follows data_write
					lru_touch = 1'b1;
					state_d = st_idle;
				end else if (needs_wb) begin
					state_d = st_write_back;
				end else begin
					state_d = st_fill_wait;
				end
			end
			st_write_back: state_d = st_fill_wait;
			st_fill_wait: begin
				if (fill_match) begin
					line_fill = 1'b1;
					state_d = st_fill;
				end
			end
			st_fill: begin
				tag_write = 1'b1;  // line is in, now mark it valid
				state_d = st_apply;
			end
			st_apply: begin
				data_write = is_write;
				lru_touch = 1'b1;
				state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge main_clk) begin
		if (state_q == st_idle && req_valid) begin
			req_q <= req;
		end
	end

	always_ff @(posedge main_clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_idle;
			way_q <= '0;
			ack_q <= 1'b0;
			fill_req_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == st_lookup) begin
				way_q <= access_way;
			end
			ack_q <= (state_q == st_lookup && hit) || state_q == st_apply;
			fill_req_q <= state_d == st_fill_wait && state_q != st_fill_wait;
		end
	end

endmodule

`default_nettype wire

// File: source/memory_system.sv
`timescale 1ns/1ps
`default_nettype none

module memory_system #(
	parameter int ways = 4,
	parameter int sets = 64
) (
	input  logic main_clk,
	input  logic rst_n,
	input  logic req_valid,
	input  cache_pkg::mem_req_t req,
	output logic ack,
	output cache_pkg::line_t rdata_line,
	output logic wb_valid,
	output cache_pkg::line_xfer_t wb,
	output logic fill_req_valid,
	output logic [cache_pkg::addr_w-$clog2(cache_pkg::line_bytes)-1:0] fill_req_line,
	input  logic fill_valid,
	input  cache_pkg::line_xfer_t fill
);

	import cache_pkg::*;

	localparam int off_w = $clog2(line_bytes);
	localparam int set_w = $clog2(sets);
	localparam int way_w = $clog2(ways);
	localparam int tag_w = addr_w - off_w - set_w;

	logic [set_w-1:0] set_index;
	logic [tag_w-1:0] tag, victim_tag;
	logic [way_w-1:0] hit_way, victim_way, access_way;
	logic hit, victim_dirty;
	logic tag_write, line_fill, data_write, lru_touch;
	mem_req_t cur_req;
	byte_mask_t byte_mask;
	line_t write_line, rd_line;

	assign rdata_line = rd_line;
	// victim line address is rebuilt from its tag and the current set
	assign wb = '{line_addr: {victim_tag, set_index}, data: rd_line};

	cache_controller #(.ways(ways), .sets(sets)) u_controller (
		.main_clk(main_clk), .rst_n(rst_n),
		.req_valid(req_valid), .req(req),
		.hit(hit), .hit_way(hit_way),
		.victim_way(victim_way), .victim_tag(victim_tag), .victim_dirty(victim_dirty),
		.fill_valid(fill_valid), .fill(fill),
		.set_index(set_index), .tag(tag), .cur_req(cur_req), .access_way(access_way),
		.tag_write(tag_write), .line_fill(line_fill),
		.data_write(data_write), .lru_touch(lru_touch),
		.fill_req_valid(fill_req_valid), .fill_req_line(fill_req_line),
		.wb_valid(wb_valid), .ack(ack)
	);

	cache_tags #(.ways(ways), .sets(sets)) u_tags (
		.main_clk(main_clk), .rst_n(rst_n),
		.set_index(set_index), .tag(tag), .victim_way(victim_way),
		.tag_write(tag_write), .data_write(data_write), .access_way(access_way),
		.hit(hit), .hit_way(hit_way),
		.victim_tag(victim_tag), .victim_dirty(victim_dirty)
	);

	cache_lru #(.ways(ways), .sets(sets)) u_lru (
		.main_clk(main_clk), .rst_n(rst_n),
		.set_index(set_index), .access_way(access_way),
		.lru_touch(lru_touch), .victim_way(victim_way)
	);

	cache_data #(.ways(ways), .sets(sets)) u_data (
		.main_clk(main_clk),
		.set_index(set_index), .access_way(access_way),
		.line_fill(line_fill), .fill_line(fill.data),
		.data_write(data_write), .byte_mask(byte_mask), .write_line(write_line),
		.rd_line(rd_line)
	);

	write_merge u_merge (
		.cur_req(cur_req),
		.byte_mask(byte_mask),
		.write_line(write_line)
	);

endmodule

`default_nettype wire

// File: tb/memory_system_properties.sv
`timescale 1ns/1ps
`default_nettype none

module memory_system_properties (
	input logic main_clk,
	input logic rst_n,
	input logic req_valid,
	input logic ack,
	input logic wb_valid,
	input logic fill_req_valid
);

	int fail_count = 0;  // failed assertions so far
	logic busy_q;        // request accepted and not yet acknowledged

	// a new request may start in the ack cycle of the previous one
	always_ff @(posedge main_clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
		end else if (req_valid) begin
			busy_q <= 1'b1;
		end else if (ack) begin
			busy_q <= 1'b0;
		end
	end

	ack_one_cycle: assert property (@(posedge main_clk) disable iff (!rst_n) ack |=> !ack)
	else begin
		fail_count++;
		$error("ack high for two cycles in a row");
	end

	wb_one_cycle: assert property (@(posedge main_clk) disable iff (!rst_n)
		wb_valid |=> !wb_valid)
	else begin
		fail_count++;
		$error("wb_valid high for two cycles in a row");
	end

	fill_req_one_cycle: assert property (@(posedge main_clk) disable iff (!rst_n)
		fill_req_valid |=> !fill_req_valid)
	else begin
		fail_count++;
		$error("fill_req_valid high for two cycles in a row");
	end

	// a dirty victim goes out right before its fill request
	wb_then_fill: assert property (@(posedge main_clk) disable iff (!rst_n)
		wb_valid |=> fill_req_valid)
	else begin
		fail_count++;
		$error("wb_valid not followed by fill_req_valid on the next cycle");
	end

	no_req_while_busy: assert property (@(posedge main_clk) disable iff (!rst_n)
		busy_q && !ack |-> !req_valid)
	else begin
		fail_count++;
		$error("req_valid raised while a request was still outstanding");
	end

endmodule

`default_nettype wire

// File: tb/tb_memory_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_system;

	import cache_pkg::*;

	localparam int tb_ways = 4;
	localparam int tb_sets = 64;
	localparam int max_tests = 64;
	localparam int fields = 8;         // values per stimulus line
	localparam int reset_cycles = 5;
	localparam int cycles_per_test = 40;

	logic main_clk;
	logic rst_n;
	logic req_valid;
	mem_req_t req;
	logic ack;
	line_t rdata_line;
	logic wb_valid;
	line_xfer_t wb;
	logic fill_req_valid;
	logic [addr_w-5:0] fill_req_line;
	logic fill_valid;
	line_xfer_t fill;

	logic [31:0] stim [max_tests * fields];
	line_t backing [logic [addr_w-5:0]];  // lines the DUT wrote back
	line_t shadow [logic [addr_w-5:0]];   // memory as the requester sees it
	logic [addr_w-5:0] lru_line [tb_sets][tb_ways];  // oldest first
	logic lru_dirty [tb_sets][tb_ways];
	int lru_used [tb_sets];

	int cycle_cnt = 0;
	int cycle_limit;
	int n_tests, errors, tests_failed;
	int fill_reqs, wbs, last_fill_cycle, last_wb_cycle;
	logic [addr_w-5:0] last_fill_line;
	line_xfer_t last_wb;

	memory_system #(.ways(tb_ways), .sets(tb_sets)) u_dut (
		.main_clk(main_clk), .rst_n(rst_n),
		.req_valid(req_valid), .req(req),
		.ack(ack), .rdata_line(rdata_line),
		.wb_valid(wb_valid), .wb(wb),
		.fill_req_valid(fill_req_valid), .fill_req_line(fill_req_line),
		.fill_valid(fill_valid), .fill(fill)
	);

	bind memory_system memory_system_properties u_props (
		.main_clk(main_clk), .rst_n(rst_n), .req_valid(req_valid),
		.ack(ack), .wb_valid(wb_valid), .fill_req_valid(fill_req_valid)
	);

	initial begin
		main_clk = 1'b0;
		forever #50 main_clk = ~main_clk;
	end

	always @(posedge main_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("TEST FAIL");
			$finish;
		end
	end

	// unwritten memory, upper word address bits folded in
	function automatic line_t pattern_line(input logic [addr_w-5:0] line_addr);
		line_t l;
		logic [addr_w-2:0] word_addr;
		for (int i = 0; i < line_words; i++) begin
			word_addr = {line_addr, 3'(i)};
			l[i] = word_addr[15:0] ^ {13'd0, word_addr[18:16]} ^ 16'hA5A5;
		end
		return l;
	endfunction

	function automatic line_t memory_line(input logic [addr_w-5:0] line_addr);
		if (backing.exists(line_addr)) begin
			return backing[line_addr];
		end
		return pattern_line(line_addr);
	endfunction

	function automatic line_t shadow_line(input logic [addr_w-5:0] line_addr);
		if (shadow.exists(line_addr)) begin
			return shadow[line_addr];
		end
		return pattern_line(line_addr);
	endfunction

	task automatic apply_write(input mem_req_t r);
		logic [addr_w-5:0] la;
		line_t l;
		int off;
		la = r.addr[addr_w-1:4];
		l = shadow_line(la);
		off = int'(r.addr[3:1]);
		case (r.kind)
			acc_word_write: l[off] = r.wdata[0];
			acc_byte_write: begin
				if (r.addr[0]) begin
					l[off][7:0] = r.wdata[0][7:0];   // odd address hits the low byte
				end else begin
					l[off][15:8] = r.wdata[0][7:0];
				end
			end
			acc_stack_write: begin
				for (int i = 0; i < int'(r.count); i++) begin
					if (off + i < line_words) begin
						l[off + i] = r.wdata[i];
					end
				end
			end
			default: l = l;
		endcase
		shadow[la] = l;
	endtask

	// true LRU per set, oldest entry at index 0
	task automatic touch_line(input logic [addr_w-5:0] la, input logic is_write,
			output logic was_hit, output logic victim_dirty,
			output logic [addr_w-5:0] victim_line);
		int s;
		int pos;
		logic cur_dirty;
		s = int'(la) % tb_sets;
		pos = -1;
		victim_dirty = 1'b0;
		victim_line = '0;
		cur_dirty = 1'b0;
		for (int i = 0; i < lru_used[s]; i++) begin
			if (lru_line[s][i] == la) begin
				pos = i;
			end
		end
		was_hit = pos >= 0;
		if (was_hit) begin
			cur_dirty = lru_dirty[s][pos];
		end else if (lru_used[s] == tb_ways) begin
			victim_line = lru_line[s][0];
			victim_dirty = lru_dirty[s][0];
			pos = 0;
		end else begin
			pos = lru_used[s];
			lru_used[s]++;
		end
		for (int i = pos; i < lru_used[s] - 1; i++) begin
			lru_line[s][i] = lru_line[s][i + 1];
			lru_dirty[s][i] = lru_dirty[s][i + 1];
		end
		lru_line[s][lru_used[s] - 1] = la;  // newest
		lru_dirty[s][lru_used[s] - 1] = cur_dirty | is_write;
	endtask

	task automatic report_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("%0t %s", $time, what);
		errors++;
	endtask

	task automatic run_test(input int idx);
		mem_req_t r;
		logic [addr_w-5:0] la, victim_line;
		logic was_hit, victim_dirty;
		line_t exp_line, victim_data;
		word_t exp_word;
		int start, latency, fills0, wbs0, errors0;
		r.addr = stim[idx * fields + 1][addr_w-1:0];
		r.kind = access_kind_t'(stim[idx * fields][1:0]);
		r.count = stim[idx * fields + 2][2:0];
		for (int i = 0; i < stack_words; i++) begin
			r.wdata[i] = stim[idx * fields + 3 + i][15:0];
		end
		exp_word = stim[idx * fields + 7][15:0];
		la = r.addr[addr_w-1:4];
		errors0 = errors;
		touch_line(la, r.kind != acc_read, was_hit, victim_dirty, victim_line);
		victim_data = victim_dirty ? shadow_line(victim_line) : '0;
		apply_write(r);
		exp_line = shadow_line(la);
		fills0 = fill_reqs;
		wbs0 = wbs;
		req = r;
		req_valid = 1'b1;
		start = cycle_cnt;
		@(negedge main_clk);
		req_valid = 1'b0;
		while (!ack) begin
			@(negedge main_clk);
		end
		latency = cycle_cnt - start;
		assert (rdata_line == exp_line)
		else report_value("rdata_line", exp_line, rdata_line);
		if (r.kind == acc_read) begin
			assert (rdata_line[r.addr[3:1]] == exp_word)
			else report_value("rdata_line word", 128'(exp_word), 128'(rdata_line[r.addr[3:1]]));
		end
		if (was_hit) begin
			assert (latency == 2) else report_value("ack latency", 128'(2), 128'(latency));
			assert (fill_reqs == fills0) else report_problem("a hit issued a fill request");
		end else begin
			assert (fill_reqs == fills0 + 1) else report_problem("a miss issued no fill request");
			assert (last_fill_line == la)
			else report_value("fill_req_line", 128'(la), 128'(last_fill_line));
		end
		if (victim_dirty) begin
			assert (wbs == wbs0 + 1) else report_problem("dirty victim was not written back");
			assert (last_wb.line_addr == victim_line)
			else report_value("wb.line_addr", 128'(victim_line), 128'(last_wb.line_addr));
			assert (last_wb.data == victim_data)
			else report_value("wb.data", victim_data, last_wb.data);
			assert (last_wb_cycle < last_fill_cycle)
			else report_problem("write-back did not come before the fill request");
		end else begin
			assert (wbs == wbs0) else report_problem("unexpected write-back");
		end
		@(negedge main_clk);  // one quiet cycle between requests
		if (errors == errors0) begin
			$display("test %0d %s addr %05h ok, latency %0d", idx, r.kind.name(), r.addr, latency);
		end else begin
			tests_failed++;
			$display("test %0d %s addr %05h failed", idx, r.kind.name(), r.addr);
		end
	endtask

	// backing memory, answers each fill request after 1 to 4 cycles
	initial begin
		int delay;
		logic [addr_w-5:0] pend_line;
		fill_valid = 1'b0;
		fill = '0;
		delay = 0;
		pend_line = '0;
		void'($urandom(32'h66ce));
		forever begin
			@(negedge main_clk);
			fill_valid = 1'b0;
			if (delay > 0) begin
				delay--;
				if (delay == 0) begin
					fill_valid = 1'b1;
					fill.line_addr = pend_line;
					fill.data = memory_line(pend_line);
				end
			end
			if (fill_req_valid) begin
				pend_line = fill_req_line;
				delay = 1 + int'($urandom % 4);
				fill_reqs++;
				last_fill_line = fill_req_line;
				last_fill_cycle = cycle_cnt;
			end
			if (wb_valid) begin
				backing[wb.line_addr] = wb.data;
				last_wb = wb;
				last_wb_cycle = cycle_cnt;
				wbs++;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		errors = 0;
		tests_failed = 0;
		fill_reqs = 0;
		wbs = 0;
		foreach (stim[i]) begin
			stim[i] = '1;  // all ones marks the end of the data
		end
		$readmemh("tb/cache_stimulus.txt", stim);
		n_tests = 0;
		while (n_tests < max_tests && stim[n_tests * fields] != '1) begin
			n_tests++;
		end
		cycle_limit = cycles_per_test * n_tests + reset_cycles;
		repeat (reset_cycles) @(negedge main_clk);
		rst_n = 1'b1;
		assert (!ack && !wb_valid && !fill_req_valid)
		else report_problem("a strobe output is high right after reset");
		assert (n_tests > 0) else report_problem("no stimulus lines could be read");
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		if (u_dut.u_props.fail_count != 0) begin
			report_problem("bound protocol assertions failed");
		end
		$display("tests run %0d, ok %0d, failed %0d, errors %0d",
			n_tests, n_tests - tests_failed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/cache_stimulus.txt
// op (0 read, 1 word write, 2 byte write, 3 stack write), byte address, stack count,
// write words 0 to 3, expected word at the address for reads (0 otherwise)
0 00100 0 0000 0000 0000 0000 a525
0 0010a 0 0000 0000 0000 0000 a520
1 00104 0 1234 0000 0000 0000 0000
0 00104 0 0000 0000 0000 0000 1234
2 00107 0 00cd 0000 0000 0000 0000
2 00106 0 00ef 0000 0000 0000 0000
0 00106 0 0000 0000 0000 0000 efcd
3 00200 1 1111 0000 0000 0000 0000
3 00204 2 2222 3333 0000 0000 0000
3 0030c 4 4444 5555 6666 7777 0000
0 0030e 0 0000 0000 0000 0000 5555
0 00300 0 0000 0000 0000 0000 a425
3 00208 3 8888 9999 aaaa 0000 0000
0 0020c 0 0000 0000 0000 0000 aaaa
0 00206 0 0000 0000 0000 0000 3333
1 00450 0 beef 0000 0000 0000 0000
0 00850 0 0000 0000 0000 0000 a18d
0 00c50 0 0000 0000 0000 0000 a38d
0 01050 0 0000 0000 0000 0000 ad8d
0 00450 0 0000 0000 0000 0000 beef
0 01450 0 0000 0000 0000 0000 af8d
0 00c50 0 0000 0000 0000 0000 a38d
0 01050 0 0000 0000 0000 0000 ad8d
0 00850 0 0000 0000 0000 0000 a18d
0 00450 0 0000 0000 0000 0000 beef

// File: compile.f
source/cache_pkg.sv
source/cache_tags.sv
source/cache_lru.sv
source/cache_data.sv
source/write_merge.sv
source/cache_controller.sv
source/memory_system.sv
tb/memory_system_properties.sv
tb/tb_memory_system.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tb_memory_system
FILELIST := compile.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
